//--- hw/tile_pkg.sv
package tile_pkg;

	// tile types as stored in the maps
	typedef enum logic [2:0] {
		FREE  = 3'd0,
		REGU  = 3'd1,
		GATE  = 3'd2,
		COIN  = 3'd3,
		TPORT = 3'd4,
		SPIKE = 3'd5,
		BRAKE = 3'd6
	} tile_t;

	// screen grid of 64x64 tiles
	localparam int NUM_COLS   = 10;
	localparam int NUM_ROWS   = 7;
	localparam int COL_W      = 4;
	localparam int ROW_W      = 3;
	localparam int TILE_SHIFT = 6;  // log2 of tile size
	localparam int COORD_W    = 11; // vga pixel coordinate width

	// cell covered by the gate
	localparam int GATE_ROW = 6;
	localparam int GATE_COL = 4;

	// slots of the neighbour area
	localparam int AREA_LEFT  = 0;
	localparam int AREA_UP    = 1;
	localparam int AREA_RIGHT = 2;
	localparam int AREA_DOWN  = 3;

	// teleport target, column in [7:4], row in [3:0]
	localparam logic [7:0] TPORT_DEFAULT = 8'h09;

	localparam tile_t LEVEL_MAPS [2][NUM_ROWS][NUM_COLS] = '{
		'{ // level 0
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{BRAKE, FREE,  FREE,  FREE,  REGU,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{FREE,  FREE,  COIN,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{FREE,  BRAKE, FREE,  REGU,  FREE,  REGU,  FREE,  COIN,  FREE,  REGU },
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  REGU,  FREE,  FREE,  FREE },
			'{REGU,  FREE,  BRAKE, BRAKE, FREE,  FREE,  FREE,  FREE,  REGU,  FREE },
			'{FREE,  TPORT, REGU,  REGU,  FREE,  SPIKE, FREE,  TPORT, FREE,  REGU }
		},
		'{ // level 1
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{BRAKE, FREE,  FREE,  FREE,  FREE,  COIN,  BRAKE, FREE,  FREE,  FREE },
			'{FREE,  FREE,  FREE,  FREE,  BRAKE, FREE,  FREE,  FREE,  BRAKE, FREE },
			'{FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE,  FREE },
			'{SPIKE, REGU,  BRAKE, REGU,  REGU,  REGU,  REGU,  REGU,  REGU,  REGU }
		}
	};

	// the two portals in row 6 lead to each other
	localparam logic [7:0] TELEPORT_MAP [NUM_ROWS][NUM_COLS] = '{
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09},
		'{8'h09, 8'h76, 8'h09, 8'h09, 8'h09, 8'h09, 8'h09, 8'h16, 8'h09, 8'h09}
	};

endpackage

//--- hw/tile_decode.sv
`timescale 1ns/1ps

module tile_decode (
	input  logic [tile_pkg::COORD_W-1:0] pixel_x,
	input  logic [tile_pkg::COORD_W-1:0] pixel_y,
	input  logic [tile_pkg::COORD_W-1:0] player_x,
	input  logic [tile_pkg::COORD_W-1:0] player_y,
	output logic [tile_pkg::COL_W-1:0]   scan_col,
	output logic [tile_pkg::ROW_W-1:0]   scan_row,
	output logic                         scan_in_grid,
	output logic [tile_pkg::COL_W-1:0]   player_col,
	output logic [tile_pkg::ROW_W-1:0]   player_row,
	output logic                         player_in_grid
);

	import tile_pkg::*;

	// pixel to column index, clamped to all ones
	function automatic logic [COL_W-1:0] to_col(input logic [COORD_W-1:0] x);
		logic [COORD_W-1:0] q;
		q = x >> TILE_SHIFT;
		if (q[COORD_W-1:COL_W] != '0)
			return '1;
		return q[COL_W-1:0];
	endfunction

	// same for rows
	function automatic logic [ROW_W-1:0] to_row(input logic [COORD_W-1:0] y);
		logic [COORD_W-1:0] q;
		q = y >> TILE_SHIFT;
		if (q[COORD_W-1:ROW_W] != '0)
			return '1;
		return q[ROW_W-1:0];
	endfunction

	always_comb begin
		scan_col   = to_col(pixel_x);
		scan_row   = to_row(pixel_y);
		player_col = to_col(player_x);
		player_row = to_row(player_y);
	end

	// clamped values are 15 and 7, both already past the grid edge
	always_comb begin
		scan_in_grid   = (scan_col < NUM_COLS) && (scan_row < NUM_ROWS);
		player_in_grid = (player_col < NUM_COLS) && (player_row < NUM_ROWS);
	end

endmodule

//--- hw/tile_map.sv
`timescale 1ns/1ps

module tile_map (
	input  logic                       clk,
	input  logic                       resetN,
	input  logic                       gate,
	input  logic                       level,
	input  logic [tile_pkg::COL_W-1:0] scan_col,
	input  logic [tile_pkg::ROW_W-1:0] scan_row,
	input  logic                       scan_in_grid,
	input  logic [tile_pkg::COL_W-1:0] player_col,
	input  logic [tile_pkg::ROW_W-1:0] player_row,
	input  logic                       player_in_grid,
	output tile_pkg::tile_t            scan_tile,
	output tile_pkg::tile_t            neighbour_tiles [4],
	output logic [7:0]                 teleport_entry
);

	import tile_pkg::*;

	logic gate_active; // gate input, one clock late

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			gate_active <= 1'b0;
		else
			gate_active <= gate;
	end

	// one map read with the gate overlay applied, cell must be in the grid
	function automatic tile_t map_cell(
		input logic             lvl,
		input logic             gated,
		input logic [ROW_W-1:0] row,
		input logic [COL_W-1:0] col
	);
		if (gated && (row == GATE_ROW) && (col == GATE_COL))
			return GATE;
		return LEVEL_MAPS[lvl][row][col];
	endfunction

	// tile under the scan pixel
	always_comb begin
		if (scan_in_grid)
			scan_tile = map_cell(level, gate_active, scan_row, scan_col);
		else
			scan_tile = FREE;
	end

	// four neighbours of the player, FREE beyond the grid edge
	always_comb begin
		neighbour_tiles[AREA_LEFT]  = FREE;
		neighbour_tiles[AREA_UP]    = FREE;
		neighbour_tiles[AREA_RIGHT] = FREE;
		neighbour_tiles[AREA_DOWN]  = FREE;
		if (player_in_grid) begin
			if (player_col != 0) // left column has no left neighbour
				neighbour_tiles[AREA_LEFT] =
					map_cell(level, gate_active, player_row, player_col - 1'b1);
			if (player_row != 0)
				neighbour_tiles[AREA_UP] =
					map_cell(level, gate_active, player_row - 1'b1, player_col);
			if (player_col != NUM_COLS - 1)
				neighbour_tiles[AREA_RIGHT] =
					map_cell(level, gate_active, player_row, player_col + 1'b1);
			if (player_row != NUM_ROWS - 1) // bottom row
				neighbour_tiles[AREA_DOWN] =
					map_cell(level, gate_active, player_row + 1'b1, player_col);
		end
	end

	// portal target of the tile under the player
	always_comb begin
		if (player_in_grid)
			teleport_entry = TELEPORT_MAP[player_row][player_col];
		else
			teleport_entry = TPORT_DEFAULT;
	end

endmodule

//--- hw/tile_result.sv
`timescale 1ns/1ps

module tile_result (
	input  logic                         clk,
	input  logic                         resetN,
	input  logic [tile_pkg::COL_W-1:0]   scan_col,
	input  logic [tile_pkg::ROW_W-1:0]   scan_row,
	input  tile_pkg::tile_t              scan_tile,
	input  tile_pkg::tile_t              neighbour_tiles [4],
	input  logic [7:0]                   teleport_entry,
	output tile_pkg::tile_t              step_type,
	output logic [tile_pkg::COORD_W-1:0] tile_left,
	output logic [tile_pkg::COORD_W-1:0] tile_top,
	output tile_pkg::tile_t              area [4],
	output logic [7:0]                   teleport_coords
);

	import tile_pkg::*;

	logic [COORD_W-1:0] corner_x;
	logic [COORD_W-1:0] corner_y;

	// top-left pixel of the scan tile, also off the grid
	always_comb begin
		corner_x = COORD_W'(scan_col) << TILE_SHIFT;
		corner_y = COORD_W'(scan_row) << TILE_SHIFT;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			step_type       <= FREE;
			tile_left       <= '0;
			tile_top        <= '0;
			teleport_coords <= '0;
			for (int i = 0; i < 4; i++)
				area[i] <= FREE;
		end else begin
			step_type       <= scan_tile;
			tile_left       <= corner_x;
			tile_top        <= corner_y;
			teleport_coords <= teleport_entry; // col in high nibble
			for (int i = 0; i < 4; i++)
				area[i] <= neighbour_tiles[i];
		end
	end

endmodule

//--- hw/tile_grid_top.sv
`timescale 1ns/1ps

module tile_grid_top (
	input  logic                         clk,
	input  logic                         resetN,
	input  logic [tile_pkg::COORD_W-1:0] pixel_x,
	input  logic [tile_pkg::COORD_W-1:0] pixel_y,
	input  logic [tile_pkg::COORD_W-1:0] player_x,
	input  logic [tile_pkg::COORD_W-1:0] player_y,
	input  logic                         gate,
	input  logic                         level,
	output tile_pkg::tile_t              step_type,
	output logic [tile_pkg::COORD_W-1:0] tile_left,
	output logic [tile_pkg::COORD_W-1:0] tile_top,
	output tile_pkg::tile_t              area [4],
	output logic [7:0]                   teleport_coords
);

	import tile_pkg::*;

	logic [COL_W-1:0] scan_col;
	logic [ROW_W-1:0] scan_row;
	logic             scan_in_grid;
	logic [COL_W-1:0] player_col;
	logic [ROW_W-1:0] player_row;
	logic             player_in_grid;
	tile_t            scan_tile;
	tile_t            neighbour_tiles [4];
	logic [7:0]       teleport_entry;

	tile_decode u_decode (
		.pixel_x        (pixel_x),
		.pixel_y        (pixel_y),
		.player_x       (player_x),
		.player_y       (player_y),
		.scan_col       (scan_col),
		.scan_row       (scan_row),
		.scan_in_grid   (scan_in_grid),
		.player_col     (player_col),
		.player_row     (player_row),
		.player_in_grid (player_in_grid)
	);

	tile_map u_map (
		.clk             (clk),
		.resetN          (resetN),
		.gate            (gate),
		.level           (level),
		.scan_col        (scan_col),
		.scan_row        (scan_row),
		.scan_in_grid    (scan_in_grid),
		.player_col      (player_col),
		.player_row      (player_row),
		.player_in_grid  (player_in_grid),
		.scan_tile       (scan_tile),
		.neighbour_tiles (neighbour_tiles),
		.teleport_entry  (teleport_entry)
	);

	tile_result u_result (
		.clk             (clk),
		.resetN          (resetN),
		.scan_col        (scan_col),
		.scan_row        (scan_row),
		.scan_tile       (scan_tile),
		.neighbour_tiles (neighbour_tiles),
		.teleport_entry  (teleport_entry),
		.step_type       (step_type),
		.tile_left       (tile_left),
		.tile_top        (tile_top),
		.area            (area),
		.teleport_coords (teleport_coords)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	localparam int HALF_NS = PERIOD_NS / 2;

	initial begin
		clk = 1'b0; // first rising edge after half a period
	end

	always begin
		#(HALF_NS);
		clk = ~clk;
	end

endmodule

//--- tests/tile_grid_tb.sv
`timescale 1ns/1ps

module tile_grid_tb;

	import tile_pkg::*;

	localparam int WAIT_LIMIT = 100;       // 1 ns polling steps per clock edge
	localparam int TILE_PX = 64;
	localparam logic [7:0] DEFAULT_TARGET = 8'h09; // column 0 and row 9

	logic clk;
	logic resetN;
	logic [COORD_W-1:0] pixel_x;
	logic [COORD_W-1:0] pixel_y;
	logic [COORD_W-1:0] player_x;
	logic [COORD_W-1:0] player_y;
	logic gate;
	logic level;
	tile_t step_type;
	logic [COORD_W-1:0] tile_left;
	logic [COORD_W-1:0] tile_top;
	tile_t area [4];
	logic [7:0] teleport_coords;

	int seed = 32'h48b4_b134;
	logic gate_model; // what gate_active should hold
	int scan_gate_hits;
	int area_gate_hits;
	tile_t exp_step;
	int exp_left;
	int exp_top;
	tile_t exp_area [4];
	logic [7:0] exp_tport;

	tb_clock #(.PERIOD_NS(20)) u_clock (.clk(clk));

	tile_grid_top DUT (
		.clk             (clk),
		.resetN          (resetN),
		.pixel_x         (pixel_x),
		.pixel_y         (pixel_y),
		.player_x        (player_x),
		.player_y        (player_y),
		.gate            (gate),
		.level           (level),
		.step_type       (step_type),
		.tile_left       (tile_left),
		.tile_top        (tile_top),
		.area            (area),
		.teleport_coords (teleport_coords)
	);

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// random pixel inside tile number idx
	function automatic logic [COORD_W-1:0] pos_in_cell(input int idx);
		return COORD_W'(idx * TILE_PX + rand_range(0, TILE_PX - 1));
	endfunction

	// reference lookup that gives FREE anywhere off the grid
	function automatic tile_t model_cell(input int lvl, input logic gated, input int row,
		input int col);
		if (row < 0 || row >= NUM_ROWS || col < 0 || col >= NUM_COLS)
			return FREE;
		if (gated && row == GATE_ROW && col == GATE_COL)
			return GATE;
		return LEVEL_MAPS[lvl][row][col];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic wait_fall(input string what);
		int steps;
		steps = 0;
		while (clk !== 1'b1 && steps < WAIT_LIMIT) begin
			#1;
			steps++;
		end
		while (clk !== 1'b0 && steps < WAIT_LIMIT) begin
			#1;
			steps++;
		end
		if (steps >= WAIT_LIMIT) begin
			$display("clock stopped while waiting for a falling edge in %s", what);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	endtask

	// expected outputs for the inputs that the next rising edge takes
	task automatic predict;
		int sc;
		int sr;
		int pc;
		int pr;
		sc = int'(pixel_x) >> TILE_SHIFT;
		sr = int'(pixel_y) >> TILE_SHIFT;
		pc = int'(player_x) >> TILE_SHIFT;
		pr = int'(player_y) >> TILE_SHIFT;
		if (sc > (1 << COL_W) - 1)
			sc = (1 << COL_W) - 1; // index saturates at its width
		if (sr > (1 << ROW_W) - 1)
			sr = (1 << ROW_W) - 1;
		exp_step = model_cell(level, gate_model, sr, sc);
		exp_left = sc << TILE_SHIFT;
		exp_top = sr << TILE_SHIFT;
		for (int i = 0; i < 4; i++)
			exp_area[i] = FREE;
		exp_tport = DEFAULT_TARGET;
		if (pc < NUM_COLS && pr < NUM_ROWS) begin
			exp_area[AREA_LEFT] = model_cell(level, gate_model, pr, pc - 1);
			exp_area[AREA_UP] = model_cell(level, gate_model, pr - 1, pc);
			exp_area[AREA_RIGHT] = model_cell(level, gate_model, pr, pc + 1);
			exp_area[AREA_DOWN] = model_cell(level, gate_model, pr + 1, pc);
			exp_tport = TELEPORT_MAP[pr][pc];
		end
		if (exp_step == GATE)
			scan_gate_hits++;
		for (int i = 0; i < 4; i++) begin
			if (exp_area[i] == GATE)
				area_gate_hits++;
		end
	endtask

	task automatic check_outputs(input string name);
		check_value({name, " step_type"}, 32'(exp_step), 32'(step_type));
		check_value({name, " tile_left"}, 32'(exp_left), 32'(tile_left));
		check_value({name, " tile_top"}, 32'(exp_top), 32'(tile_top));
		for (int i = 0; i < 4; i++)
			check_value($sformatf("%s area[%0d]", name, i), 32'(exp_area[i]), 32'(area[i]));
		check_value({name, " teleport_coords"}, 32'(exp_tport), 32'(teleport_coords));
	endtask

	task automatic check_zero(input string name);
		check_value({name, " step_type"}, 32'(FREE), 32'(step_type));
		check_value({name, " tile_left"}, 0, 32'(tile_left));
		check_value({name, " tile_top"}, 0, 32'(tile_top));
		for (int i = 0; i < 4; i++)
			check_value($sformatf("%s area[%0d]", name, i), 32'(FREE), 32'(area[i]));
		check_value({name, " teleport_coords"}, 0, 32'(teleport_coords));
	endtask

	// inputs already driven and outputs follow one edge later
	task automatic run_cycle(input string name);
		predict();
		gate_model = gate; // gate_active takes it on the same edge
		wait_fall(name);
		check_outputs(name);
	endtask

	initial begin
		resetN = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		player_x = '0;
		player_y = '0;
		gate = 1'b0;
		level = 1'b0;
		gate_model = 1'b0;
		scan_gate_hits = 0;
		area_gate_hits = 0;
		#0.5; // poll half a ns away from clock edges

		for (int i = 0; i < 3; i++) begin
			wait_fall("reset");
			check_zero("reset");
		end
		resetN = 1'b1;
		#1;
		check_zero("after reset");

		// scan lookup inside the grid on both maps
		for (int lvl = 0; lvl < 2; lvl++) begin
			for (int i = 0; i < 150; i++) begin
				level = lvl[0];
				pixel_x = COORD_W'(rand_range(0, NUM_COLS * TILE_PX - 1));
				pixel_y = COORD_W'(rand_range(0, NUM_ROWS * TILE_PX - 1));
				player_x = pos_in_cell(rand_range(0, NUM_COLS - 1));
				player_y = pos_in_cell(rand_range(0, NUM_ROWS - 1));
				run_cycle("scan lookup");
			end
		end

		// scan pixel past column 9 or row 6
		for (int i = 0; i < 100; i++) begin
			if (rand_range(0, 1) == 0) begin
				pixel_x = COORD_W'(rand_range(NUM_COLS * TILE_PX, 2047));
				pixel_y = COORD_W'(rand_range(0, 2047));
			end else begin
				pixel_x = COORD_W'(rand_range(0, 2047));
				pixel_y = COORD_W'(rand_range(NUM_ROWS * TILE_PX, 2047));
			end
			run_cycle("off-grid scan");
		end

		// gate toggles at random around cell (6,4)
		for (int i = 0; i < 200; i++) begin
			level = (i >= 100);
			if (rand_range(0, 3) == 0)
				gate = ~gate;
			pixel_x = pos_in_cell(rand_range(0, 3) == 0 ? rand_range(0, 9) : GATE_COL);
			pixel_y = pos_in_cell(rand_range(0, 3) == 0 ? rand_range(0, 6) : GATE_ROW);
			case (rand_range(0, 2))
				0: begin
					player_x = pos_in_cell(GATE_COL - 1);
					player_y = pos_in_cell(GATE_ROW);
				end
				1: begin
					player_x = pos_in_cell(GATE_COL + 1);
					player_y = pos_in_cell(GATE_ROW);
				end
				default: begin
					player_x = pos_in_cell(GATE_COL);
					player_y = pos_in_cell(GATE_ROW - 1);
				end
			endcase
			run_cycle("gate overlay");
		end
		check_value("gate overlay seen on scan", 1, 32'(scan_gate_hits > 0));
		check_value("gate overlay seen on area", 1, 32'(area_gate_hits > 0));
		gate = 1'b0;
		run_cycle("gate drop");

		// neighbour area with corners first and then edges and off-grid positions
		for (int i = 0; i < 200; i++) begin
			level = (i >= 100);
			if (i % 100 < 4) begin
				player_x = pos_in_cell((i % 2 == 0) ? 0 : NUM_COLS - 1);
				player_y = pos_in_cell((i % 4 < 2) ? 0 : NUM_ROWS - 1);
			end else if (rand_range(0, 7) == 0) begin
				player_x = COORD_W'(rand_range(0, 2047));
				player_y = COORD_W'(rand_range(0, 2047));
			end else begin
				player_x = pos_in_cell(rand_range(0, NUM_COLS + 1));
				player_y = pos_in_cell(rand_range(0, NUM_ROWS + 1));
			end
			run_cycle("neighbour area");
		end

		// portals of level 0 sit at (6,1) and (6,7)
		level = 1'b0;
		for (int i = 0; i < 100; i++) begin
			case (rand_range(0, 3))
				0: player_x = pos_in_cell(1);
				1: player_x = pos_in_cell(7);
				default: player_x = pos_in_cell(rand_range(0, NUM_COLS - 1));
			endcase
			player_y = pos_in_cell(rand_range(0, 1) == 0 ? NUM_ROWS - 1 : rand_range(0, 6));
			run_cycle("teleport");
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- tb.f
hw/tile_pkg.sv
hw/tile_decode.sv
hw/tile_map.sv
hw/tile_result.sv
hw/tile_grid_top.sv
tests/tb_clock.sv
tests/tile_grid_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tile grid testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=tile_grid_sim

verilator --binary --timing -Wno-fatal --top-module tile_grid_tb \
	-f tb.f --Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi
